//--- common/digital_core_pkg.sv
// Shared Wishbone types and memory map codes for the crossbar
// Bus is fixed at 32 bits with one byte enable per byte
// Only address bits 31:28 take part in the slave decode

package digital_core_pkg;

    //--------------------------------------------------
    // Bus widths
    //--------------------------------------------------
    localparam int WB_WIDTH  = 32;              // Address and data width
    localparam int SEL_WIDTH = WB_WIDTH / 8;    // One enable per byte
    localparam int TAR_WIDTH = 4;               // Region field, top nibble

    //--------------------------------------------------
    // Word types
    //--------------------------------------------------
    typedef logic [WB_WIDTH-1:0]  wb_data_t;    // Data or address word
    typedef logic [SEL_WIDTH-1:0] wb_sel_t;     // Byte enable
    typedef logic [TAR_WIDTH-1:0] wb_tar_t;     // Memory map region

    // Address word, seen raw by the slaves or as region plus offset
    // by the decoder
    typedef union packed {
        wb_data_t raw;
        struct packed {
            wb_tar_t                       tar;    // Bits 31:28
            logic [WB_WIDTH-TAR_WIDTH-1:0] ofs;    // Offset inside region
        } region;
    } wb_adr_u;

    //--------------------------------------------------
    // Memory map regions
    //--------------------------------------------------
    // 0x0xxx_xxxx  SPI flash
    // 0x1xxx_xxxx  SPI registers
    // 0x2xxx_xxxx  SDRAM
    // 0x3xxx_xxxx  Global registers
    // anything else lands on SPI
    localparam wb_tar_t MAP_SPI_FLASH = 4'h0;
    localparam wb_tar_t MAP_SPI_REG   = 4'h1;
    localparam wb_tar_t MAP_SDRAM     = 4'h2;
    localparam wb_tar_t MAP_GLBL      = 4'h3;

    //--------------------------------------------------
    // Slave port indices
    //--------------------------------------------------
    // Same order as the slave vectors on the top level
    localparam int TAR_SPIM  = 0;
    localparam int TAR_SDRAM = 1;
    localparam int TAR_GLBL  = 2;

endpackage : digital_core_pkg

//--- wb_crossbar/wb_target_decode.sv
`timescale 1ns/1ps
// Address decode for every master, one request bit per slave
// Memory map is fixed, so NUM_SLAVES must stay at 3
// Regions 4 to 15 fall back to the SPI slave

module wb_target_decode #(
    parameter int NUM_MASTERS = 3,
    parameter int NUM_SLAVES  = 3
) (
    input  logic [NUM_MASTERS-1:0]                       mst_stb_i,  // Master strobes
    input  digital_core_pkg::wb_adr_u [NUM_MASTERS-1:0]  mst_adr_i,  // Master addresses
    output logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]       slv_req_o   // Per slave, per master
);

    //--------------------------------------------------
    // Per master region lookup
    //--------------------------------------------------
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst

        logic [NUM_SLAVES-1:0] hit;    // One-hot target of this master

        always_comb begin
            hit = '0;
            case (mst_adr_i[m].region.tar)
                digital_core_pkg::MAP_SPI_FLASH,
                digital_core_pkg::MAP_SPI_REG: begin
                    hit[digital_core_pkg::TAR_SPIM] = 1'b1;    // Flash and SPI regs
                end
                digital_core_pkg::MAP_SDRAM: begin
                    hit[digital_core_pkg::TAR_SDRAM] = 1'b1;
                end
                digital_core_pkg::MAP_GLBL: begin
                    hit[digital_core_pkg::TAR_GLBL] = 1'b1;
                end
                default: begin
                    // Unmapped space still needs an owner
                    hit[digital_core_pkg::TAR_SPIM] = 1'b1;
                end
            endcase
        end

        // Gate with strobe, so an idle master asks for nothing
        for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
            assign slv_req_o[s][m] = mst_stb_i[m] & hit[s];
        end

    end

endmodule : wb_target_decode

//--- wb_crossbar/wb_slave_port.sv
`timescale 1ns/1ps
// Round-robin arbiter and request mux in front of one slave
// Grant lives from the edge after a request to the edge after ack or err
// Slave cyc is a copy of stb, no lock across back-to-back transfers
// One idle cycle at least between two grants

module wb_slave_port #(
    parameter int NUM_MASTERS = 3
) (
    input  logic                                          clk,
    input  logic                                          arst_n_i,
    input  logic [NUM_MASTERS-1:0]                        req_i,      // Decoded requests
    input  digital_core_pkg::wb_adr_u  [NUM_MASTERS-1:0]  mst_adr_i,
    input  digital_core_pkg::wb_data_t [NUM_MASTERS-1:0]  mst_dat_i,
    input  digital_core_pkg::wb_sel_t  [NUM_MASTERS-1:0]  mst_sel_i,
    input  logic [NUM_MASTERS-1:0]                        mst_we_i,
    input  logic                                          slv_ack_i,
    input  logic                                          slv_err_i,
    output logic                                          slv_stb_o,
    output logic                                          slv_cyc_o,
    output logic                                          slv_we_o,
    output digital_core_pkg::wb_data_t                    slv_adr_o,
    output digital_core_pkg::wb_data_t                    slv_dat_o,
    output digital_core_pkg::wb_sel_t                     slv_sel_o,
    output logic [NUM_MASTERS-1:0]                        grant_o     // One-hot owner
);

    localparam int IW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    logic [NUM_MASTERS-1:0] grant_q;     // Current owner, one-hot
    logic [IW-1:0]          last_q;      // Index of current or last owner
    logic [NUM_MASTERS-1:0] pick_oh;     // Next owner, one-hot
    logic [IW-1:0]          pick_idx;    // Next owner, index
    logic                   busy;        // Grant held
    logic                   hold;        // Owner still asking
    logic                   done;        // Slave has replied

    assign busy = |grant_q;
    assign hold = |(grant_q & req_i);
    assign done = slv_ack_i | slv_err_i;

    //--------------------------------------------------
    // Round-robin pick
    //--------------------------------------------------
    // Search starts one past the last owner and wraps
    always_comb begin : p_rr
        int idx;
        pick_oh  = '0;
        pick_idx = last_q;
        for (int k = 1; k <= NUM_MASTERS; k++) begin
            idx = (int'(last_q) + k) % NUM_MASTERS;
            if (req_i[idx] && (pick_oh == '0)) begin
                pick_oh[idx] = 1'b1;    // First requester wins
                pick_idx     = IW'(idx);
            end
        end
    end

    //--------------------------------------------------
    // Grant register
    //--------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= '0;
            last_q  <= IW'(NUM_MASTERS - 1);    // Master 0 goes first
        end else if (busy) begin
            // Release on reply, or when the owner withdrew
            if (done || !hold) begin
                grant_q <= '0;
            end
        end else if (|req_i) begin
            grant_q <= pick_oh;
            last_q  <= pick_idx;    // Also the mux select below
        end
    end

    //--------------------------------------------------
    // Request mux toward the slave
    //--------------------------------------------------
    assign slv_stb_o = hold;
    assign slv_cyc_o = hold;                       // Follows stb
    assign slv_adr_o = mst_adr_i[last_q].raw;      // Full address, not just offset
    assign slv_dat_o = mst_dat_i[last_q];
    assign slv_sel_o = mst_sel_i[last_q];
    assign slv_we_o  = mst_we_i[last_q];
    assign grant_o   = grant_q;

    //--------------------------------------------------
    // Checks
    //--------------------------------------------------
    // Never two owners on one slave
    a_grant_onehot : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0(grant_q)
    ) else $error("slave port grant not one-hot: %b", grant_q);

    // Strobe only under a grant that matches the mux select
    a_stb_granted : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        slv_stb_o |-> (grant_q == (NUM_MASTERS'(1) << last_q))
    ) else $error("slave stb with grant %b off select %0d", grant_q, last_q);

    // Slave bus frozen while the slave holds off ack
    a_grant_stable : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (slv_stb_o && !done) |=> $stable(grant_q)
    ) else $error("grant moved during a wait state");

endmodule : wb_slave_port

//--- wb_crossbar/wb_master_resp.sv
`timescale 1ns/1ps
// Routes slave data, ack and err back to the owning master
// Purely combinational, same cycle as the slave reply
// A master with no grant sees zero data and no ack or err

module wb_master_resp #(
    parameter int NUM_MASTERS = 3,
    parameter int NUM_SLAVES  = 3
) (
    input  logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]        grant_i,     // Grant per slave
    input  digital_core_pkg::wb_data_t [NUM_SLAVES-1:0]   slv_dat_i,
    input  logic [NUM_SLAVES-1:0]                         slv_ack_i,
    input  logic [NUM_SLAVES-1:0]                         slv_err_i,
    output digital_core_pkg::wb_data_t [NUM_MASTERS-1:0]  mst_dat_o,
    output logic [NUM_MASTERS-1:0]                        mst_ack_o,
    output logic [NUM_MASTERS-1:0]                        mst_err_o
);

    //--------------------------------------------------
    // Per master return path
    //--------------------------------------------------
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst

        logic [NUM_SLAVES-1:0]      owner;    // Slaves granting this master
        digital_core_pkg::wb_data_t dat;      // AND-OR data mux

        // Transpose grants into this master's column
        for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_col
            assign owner[s] = grant_i[s][m];
        end

        always_comb begin
            dat = '0;
            for (int s = 0; s < NUM_SLAVES; s++) begin
                dat |= slv_dat_i[s] & {digital_core_pkg::WB_WIDTH{owner[s]}};
            end
        end

        assign mst_dat_o[m] = dat;
        assign mst_ack_o[m] = |(owner & slv_ack_i);
        assign mst_err_o[m] = |(owner & slv_err_i);    // Only the owner sees err

        // A master waits on one slave at a time, so two grants
        // point at a decode or arbiter fault
        always_comb begin
            a_single_owner : assert #0 ($onehot0(owner))
                else $error("master %0d granted by slaves %b", m, owner);
        end

    end

endmodule : wb_master_resp

//--- src/digital_core.sv
`timescale 1ns/1ps
// Wishbone crossbar of the digital core, three masters onto three slaves
// Master order is imem, dmem, ext; slave order is SPI, SDRAM, global regs
// NUM_SLAVES is tied to the memory map and must stay at 3
// No retry, no burst, classic stb/ack handshake only

module digital_core #(
    parameter int NUM_MASTERS = 3,
    parameter int NUM_SLAVES  = 3
) (
    input  logic                                          clk,         // System clock
    input  logic                                          arst_n_i,

    //--------------------------------------------------
    // Master side
    //--------------------------------------------------
    input  logic [NUM_MASTERS-1:0]                        mst_stb_i,   // Strobe, also cyc
    input  logic [NUM_MASTERS-1:0]                        mst_we_i,
    input  digital_core_pkg::wb_data_t [NUM_MASTERS-1:0]  mst_adr_i,
    input  digital_core_pkg::wb_data_t [NUM_MASTERS-1:0]  mst_dat_i,   // Write data
    input  digital_core_pkg::wb_sel_t  [NUM_MASTERS-1:0]  mst_sel_i,
    output digital_core_pkg::wb_data_t [NUM_MASTERS-1:0]  mst_dat_o,   // Read data
    output logic [NUM_MASTERS-1:0]                        mst_ack_o,
    output logic [NUM_MASTERS-1:0]                        mst_err_o,

    //--------------------------------------------------
    // Slave side
    //--------------------------------------------------
    output logic [NUM_SLAVES-1:0]                         slv_stb_o,
    output logic [NUM_SLAVES-1:0]                         slv_cyc_o,
    output logic [NUM_SLAVES-1:0]                         slv_we_o,
    output digital_core_pkg::wb_data_t [NUM_SLAVES-1:0]   slv_adr_o,
    output digital_core_pkg::wb_data_t [NUM_SLAVES-1:0]   slv_dat_o,   // Write data
    output digital_core_pkg::wb_sel_t  [NUM_SLAVES-1:0]   slv_sel_o,
    input  digital_core_pkg::wb_data_t [NUM_SLAVES-1:0]   slv_dat_i,   // Read data
    input  logic [NUM_SLAVES-1:0]                         slv_ack_i,
    input  logic [NUM_SLAVES-1:0]                         slv_err_i
);

    logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] slv_req_w;    // Decoded requests
    logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] grant_w;      // Arbiter owners

    //--------------------------------------------------
    // Address decode
    //--------------------------------------------------
    wb_target_decode #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) u_target_decode (
        .mst_stb_i   (mst_stb_i),
        .mst_adr_i   (mst_adr_i),    // Seen as region view inside
        .slv_req_o   (slv_req_w)
    );

    //--------------------------------------------------
    // One arbiter per slave
    //--------------------------------------------------
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
        wb_slave_port #(
            .NUM_MASTERS (NUM_MASTERS)
        ) u_slave_port (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .req_i       (slv_req_w[s]),
            .mst_adr_i   (mst_adr_i),
            .mst_dat_i   (mst_dat_i),
            .mst_sel_i   (mst_sel_i),
            .mst_we_i    (mst_we_i),
            .slv_ack_i   (slv_ack_i[s]),
            .slv_err_i   (slv_err_i[s]),
            .slv_stb_o   (slv_stb_o[s]),
            .slv_cyc_o   (slv_cyc_o[s]),
            .slv_we_o    (slv_we_o[s]),
            .slv_adr_o   (slv_adr_o[s]),
            .slv_dat_o   (slv_dat_o[s]),
            .slv_sel_o   (slv_sel_o[s]),
            .grant_o     (grant_w[s])
        );
    end

    //--------------------------------------------------
    // Response return
    //--------------------------------------------------
    wb_master_resp #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) u_master_resp (
        .grant_i     (grant_w),
        .slv_dat_i   (slv_dat_i),
        .slv_ack_i   (slv_ack_i),
        .slv_err_i   (slv_err_i),
        .mst_dat_o   (mst_dat_o),
        .mst_ack_o   (mst_ack_o),
        .mst_err_o   (mst_err_o)
    );

endmodule : digital_core

//--- tests/tb_slave_model.sv
`timescale 1ns/1ps
// Behavioral Wishbone slave with random wait states and a 16 entry memory
// Entry index is address bits 6:3, err whenever address bit 2 is set
// Ack or err lasts exactly one cycle, writes land on the ack edge
// Memory fill is rebuilt on every reset

module tb_slave_model #(
    parameter int SLV_ID   = 0,        // Slave index, part of the fill word
    parameter int MAX_WAIT = 4,        // Upper bound of wait states
    parameter int SEED     = 1         // Start value of the local seed
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       stb_i,
    input  logic                       cyc_i,
    input  logic                       we_i,
    input  digital_core_pkg::wb_data_t adr_i,
    input  digital_core_pkg::wb_data_t dat_i,
    input  digital_core_pkg::wb_sel_t  sel_i,
    output digital_core_pkg::wb_data_t dat_o,
    output logic                       ack_o,
    output logic                       err_o
);

    digital_core_pkg::wb_data_t mem [16];    // Slave storage
    logic       busy_q;                      // Cycle accepted, counting
    logic       ack_q;
    logic       err_q;
    int         cnt_q;                       // Wait states left
    integer     seed;
    logic [3:0] idx;

    assign idx = adr_i[6:3];                 // Err and ack addresses share entries

    initial seed = SEED;

    // Fill word depends on slave and whole index
    function automatic digital_core_pkg::wb_data_t fill_word(input int i);
        return {4'hc, 4'(SLV_ID), 8'(i), ~8'(i), 8'(i * 37)};
    endfunction

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            cnt_q  <= 0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= fill_word(i);
            end
        end else if (ack_q || err_q) begin
            ack_q  <= 1'b0;                  // Single cycle reply
            err_q  <= 1'b0;
            busy_q <= 1'b0;
        end else if (stb_i && cyc_i) begin
            if (!busy_q) begin
                busy_q <= 1'b1;
                cnt_q  <= int'($unsigned($random(seed)) % (MAX_WAIT + 1));
            end else if (cnt_q > 0) begin
                cnt_q <= cnt_q - 1;          // Still stalling
            end else if (adr_i[2]) begin
                err_q <= 1'b1;               // Memory left alone
            end else begin
                ack_q <= 1'b1;
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end
            end
        end else begin
            busy_q <= 1'b0;
        end
    end

    assign dat_o = ack_q ? mem[idx] : '0;    // Read data only with ack
    assign ack_o = ack_q;
    assign err_o = err_q;

endmodule : tb_slave_model

//--- tests/tb_digital_core.sv
`timescale 1ns/1ps
// Random traffic testbench for the Wishbone crossbar
// Three masters run at once against three behavioral slaves
// Inputs change 1 ns after the rising edge, checks run on the falling edge
// Masters already request during reset, first grants follow its release
// A local memory copy predicts every read, err rule is address bit 2

module tb_digital_core;

    localparam int NM       = 3;        // Masters
    localparam int NS       = 3;        // Slaves
    localparam int N_TXN    = 200;      // Transactions per master
    localparam int MAX_WAIT = 4;        // Slave wait states, upper bound
    localparam int RST_CYC  = 8;
    localparam int LIMIT    = N_TXN * NM * (MAX_WAIT + 4) + RST_CYC + 50;

    logic                                 clk;
    logic                                 arst_n;
    logic [NM-1:0]                        mst_stb;
    logic [NM-1:0]                        mst_we;
    digital_core_pkg::wb_data_t [NM-1:0]  mst_adr;
    digital_core_pkg::wb_data_t [NM-1:0]  mst_dat;
    digital_core_pkg::wb_sel_t  [NM-1:0]  mst_sel;
    digital_core_pkg::wb_data_t [NM-1:0]  mst_rdat;
    logic [NM-1:0]                        mst_ack;
    logic [NM-1:0]                        mst_err;
    logic [NS-1:0]                        slv_stb;
    logic [NS-1:0]                        slv_cyc;
    logic [NS-1:0]                        slv_we;
    digital_core_pkg::wb_data_t [NS-1:0]  slv_adr;
    digital_core_pkg::wb_data_t [NS-1:0]  slv_wdat;
    digital_core_pkg::wb_sel_t  [NS-1:0]  slv_sel;
    digital_core_pkg::wb_data_t [NS-1:0]  slv_rdat;
    logic [NS-1:0]                        slv_ack;
    logic [NS-1:0]                        slv_err;

    integer                     seed;
    logic                       failed;
    logic                       rst_tail;            // First cycle out of reset
    logic [NM-1:0]              resp_seen;           // Ack or err seen, drop stb
    int                         sent [NM];
    int                         gap [NM];
    int                         waits [NM];          // Grants to others while waiting
    digital_core_pkg::wb_data_t ref_mem [NS][16];    // Expected slave contents

    digital_core #(
        .NUM_MASTERS (NM),
        .NUM_SLAVES  (NS)
    ) DUT (
        .clk(clk), .arst_n_i(arst_n),
        .mst_stb_i(mst_stb), .mst_we_i(mst_we), .mst_adr_i(mst_adr),
        .mst_dat_i(mst_dat), .mst_sel_i(mst_sel), .mst_dat_o(mst_rdat),
        .mst_ack_o(mst_ack), .mst_err_o(mst_err),
        .slv_stb_o(slv_stb), .slv_cyc_o(slv_cyc), .slv_we_o(slv_we),
        .slv_adr_o(slv_adr), .slv_dat_o(slv_wdat), .slv_sel_o(slv_sel),
        .slv_dat_i(slv_rdat), .slv_ack_i(slv_ack), .slv_err_i(slv_err)
    );

    for (genvar s = 0; s < NS; s++) begin : g_slv
        tb_slave_model #(
            .SLV_ID(s), .MAX_WAIT(MAX_WAIT), .SEED(32'h6c92_f9fb + s + 1)
        ) u_slave (
            .clk(clk), .arst_n_i(arst_n), .stb_i(slv_stb[s]), .cyc_i(slv_cyc[s]),
            .we_i(slv_we[s]), .adr_i(slv_adr[s]), .dat_i(slv_wdat[s]),
            .sel_i(slv_sel[s]), .dat_o(slv_rdat[s]), .ack_o(slv_ack[s]),
            .err_o(slv_err[s])
        );
    end

    initial clk = 1'b0;
    always #10 clk = ~clk;                           // 20 ns period

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    task automatic report_failure(input string why);
        failed = 1'b1;
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input digital_core_pkg::wb_data_t got,
                              input digital_core_pkg::wb_data_t exp);
        if (got !== exp) report_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_sel(input string name, input digital_core_pkg::wb_sel_t got,
                             input digital_core_pkg::wb_sel_t exp);
        if (got !== exp) report_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // Memory map: 0,1 SPI, 2 SDRAM, 3 global regs, rest SPI
    function automatic int slave_of(input digital_core_pkg::wb_tar_t tar);
        case (tar)
            4'h2:    return 1;
            4'h3:    return 2;
            default: return 0;
        endcase
    endfunction

    function automatic digital_core_pkg::wb_data_t ref_fill(input int s, input int i);
        return {4'hc, 4'(s), 8'(i), ~8'(i), 8'(i * 37)};
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic start_txn(input int m);
        int                        pick;
        digital_core_pkg::wb_tar_t tar;
        pick = rand_below(8);
        if (pick < 6) begin
            tar = 4'(pick % 4);                      // Bias toward mapped regions
        end else begin
            tar = 4'(rand_below(16));                // Fallback regions too
        end
        mst_adr[m] = {tar, 28'($random(seed))};
        mst_we[m]  = (rand_below(2) == 1);
        mst_dat[m] = $random(seed);
        mst_sel[m] = 4'($random(seed));
        mst_stb[m] = 1'b1;
    endtask

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    initial begin : p_stim
        int busy;
        seed = 32'h6c92_f9fb;
        failed = 1'b0;
        rst_tail = 1'b0;
        resp_seen = '0;
        mst_stb = '0;
        mst_we = '0;
        mst_adr = '0;
        mst_dat = '0;
        mst_sel = '0;
        arst_n = 1'b1;
        for (int m = 0; m < NM; m++) begin
            sent[m] = 0;
            gap[m] = rand_below(3);
            waits[m] = 0;
        end
        for (int s = 0; s < NS; s++) begin
            for (int i = 0; i < 16; i++) begin
                ref_mem[s][i] = ref_fill(s, i);
            end
        end
        for (int m = 0; m < NM; m++) begin
            start_txn(m);                            // Strobes stay up through reset
        end
        #2 arst_n = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);                              // First grants register here
        busy = 1;
        while (busy != 0) begin
            @(posedge clk);
            #1;
            busy = 0;
            for (int m = 0; m < NM; m++) begin
                if (mst_stb[m]) begin
                    if (resp_seen[m]) begin
                        mst_stb[m] = 1'b0;           // Cycle after ack or err
                        resp_seen[m] = 1'b0;
                        sent[m]++;
                        gap[m] = rand_below(3);
                    end
                end else if (sent[m] < N_TXN) begin
                    if (gap[m] > 0) begin
                        gap[m]--;
                    end else begin
                        start_txn(m);
                    end
                end
                if (mst_stb[m] || sent[m] < N_TXN) busy = 1;
            end
        end
        repeat (4) @(posedge clk);
        if (failed) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

    //--------------------------------------------------
    // Checks on the falling edge
    //--------------------------------------------------
    always @(negedge clk) begin : p_check
        int            s;
        int            idx;
        logic          exp_err;
        logic [NM-1:0] served;
        int            srv_slv [NM];
        int            owners [NS];
        if (!arst_n || rst_tail) begin
            rst_tail = !arst_n;                      // Check one more cycle after release
            for (int k = 0; k < NS; k++) begin
                check_bit($sformatf("slv_stb_o[%0d]", k), slv_stb[k], 1'b0);
                check_bit($sformatf("slv_cyc_o[%0d]", k), slv_cyc[k], 1'b0);
            end
            for (int m = 0; m < NM; m++) begin
                check_bit($sformatf("mst_ack_o[%0d]", m), mst_ack[m], 1'b0);
                check_bit($sformatf("mst_err_o[%0d]", m), mst_err[m], 1'b0);
            end
        end else begin
            served = '0;
            for (int k = 0; k < NS; k++) begin
                owners[k] = 0;
                check_bit($sformatf("slv_cyc_o[%0d]", k), slv_cyc[k], slv_stb[k]);
                if (slv_stb[k] && slave_of(slv_adr[k][31:28]) != k) begin
                    report_failure($sformatf("slave %0d strobed for address %h of another region",
                                             k, slv_adr[k]));
                end
            end
            for (int m = 0; m < NM; m++) begin
                srv_slv[m] = -1;
                if (!mst_stb[m]) begin
                    check_bit($sformatf("mst_ack_o[%0d]", m), mst_ack[m], 1'b0);
                    check_bit($sformatf("mst_err_o[%0d]", m), mst_err[m], 1'b0);
                end else if (mst_ack[m] || mst_err[m]) begin
                    s = slave_of(mst_adr[m][31:28]);
                    owners[s]++;
                    served[m] = 1'b1;
                    srv_slv[m] = s;
                    check_bit($sformatf("slv_stb_o[%0d]", s), slv_stb[s], 1'b1);
                    check_word($sformatf("slv_adr_o[%0d]", s), slv_adr[s], mst_adr[m]);
                    check_word($sformatf("slv_dat_o[%0d]", s), slv_wdat[s], mst_dat[m]);
                    check_sel($sformatf("slv_sel_o[%0d]", s), slv_sel[s], mst_sel[m]);
                    check_bit($sformatf("slv_we_o[%0d]", s), slv_we[s], mst_we[m]);
                    exp_err = mst_adr[m][2];
                    check_bit($sformatf("mst_err_o[%0d]", m), mst_err[m], exp_err);
                    check_bit($sformatf("mst_ack_o[%0d]", m), mst_ack[m], !exp_err);
                    idx = int'(mst_adr[m][6:3]);
                    if (!exp_err && mst_we[m]) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mst_sel[m][b]) ref_mem[s][idx][8*b +: 8] = mst_dat[m][8*b +: 8];
                        end
                    end else if (!exp_err) begin
                        check_word($sformatf("mst_dat_o[%0d]", m), mst_rdat[m], ref_mem[s][idx]);
                    end
                    resp_seen[m] = 1'b1;
                    waits[m] = 0;
                end
            end
            for (int k = 0; k < NS; k++) begin
                if (owners[k] > 1) begin
                    report_failure($sformatf("slave %0d answered %0d masters at once",
                                             k, owners[k]));
                end
            end
            // Fairness, count grants to others on the slave this master waits for
            for (int m = 0; m < NM; m++) begin
                if (mst_stb[m] && !served[m]) begin
                    for (int o = 0; o < NM; o++) begin
                        if (served[o] && srv_slv[o] == slave_of(mst_adr[m][31:28])) waits[m]++;
                    end
                    if (waits[m] > NM - 1) begin
                        report_failure($sformatf("master %0d passed over %0d times", m, waits[m]));
                    end
                end
            end
        end
    end

    //--------------------------------------------------
    // Watchdog
    //--------------------------------------------------
    initial begin : p_watchdog
        repeat (LIMIT) @(posedge clk);
        report_failure($sformatf("timeout, traffic did not finish within %0d cycles", LIMIT));
    end

endmodule : tb_digital_core

//--- files.f
common/digital_core_pkg.sv
wb_crossbar/wb_target_decode.sv
wb_crossbar/wb_slave_port.sv
wb_crossbar/wb_master_resp.sv
src/digital_core.sv
tests/tb_slave_model.sv
tests/tb_digital_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -f files.f \
    --top-module tb_digital_core -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in output"
    exit 1
fi
